//--- fpu_fmt_pkg.sv
package fpu_fmt_pkg;

  //////////////////////////////
  // single precision fields
  //////////////////////////////
  localparam int EXP_W   = 8;   // biased exponent
  localparam int FRAC_W  = 23;  // stored fraction, hidden bit dropped

  // internal widths of the normalize/round path
  localparam int EXP10_W   = 10;  // overflow headroom plus sign
  localparam int FRACT28_W = 28;  // {carry, hidden, fract23, round, sticky x2}
  localparam int SHIFT_W   = 5;   // align shift amount

  localparam int unsigned EXP_MAX_NORMAL = 254;  // 255 is inf/nan

  //////////////////////////////
  // special result bodies
  //////////////////////////////
  // exponent and fraction only, sign is added by the packer
  localparam logic [EXP_W+FRAC_W-1:0] INF_BODY  = {{EXP_W{1'b1}}, {FRAC_W{1'b0}}};
  localparam logic [EXP_W+FRAC_W-1:0] QNAN_BODY = {{EXP_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};
  localparam logic [EXP_W+FRAC_W-1:0] SNAN_BODY = {{EXP_W{1'b1}}, 1'b0, {(FRAC_W-1){1'b1}}};

  // result word, seen as raw bits or as ieee fields
  typedef union packed {
    logic [EXP_W+FRAC_W:0] raw;
    struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [FRAC_W-1:0] frac;
    } f;
  } sp_word_u;

endpackage

//--- fpu_ctrl_pkg.sv
package fpu_ctrl_pkg;

  // rounding modes, fpcsr encoding
  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,  // ties to even
    RM_TO_ZERO = 2'd1,  // truncate
    RM_TO_INFP = 2'd2,  // toward +inf
    RM_TO_INFM = 2'd3   // toward -inf
  } rmode_e;

  //////////////////////////////
  // exception flag word
  //////////////////////////////
  localparam int FPCSR_W = 9;

  localparam int FPCSR_OVF = 0;  // overflow
  localparam int FPCSR_UNF = 1;  // underflow
  localparam int FPCSR_SNF = 2;  // signaling nan
  localparam int FPCSR_QNF = 3;  // quiet nan
  localparam int FPCSR_ZF  = 4;  // zero
  localparam int FPCSR_IXF = 5;  // inexact
  localparam int FPCSR_IVF = 6;  // invalid
  localparam int FPCSR_INF = 7;  // infinity
  localparam int FPCSR_DZF = 8;  // divide by zero

endpackage

//--- fpu_align.sv
module fpu_align (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush_i,  // drop pipe contents
  input  logic                             adv_i,    // advance pipe
  input  fpu_ctrl_pkg::rmode_e             rmode_i,
  // add/sub source
  input  logic                             add_rdy_i,
  input  logic                             add_sign_i,
  input  logic                             add_sub_0_i,  // exact zero from subtraction
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]  add_shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  add_exp10shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  add_exp10sh0_i,
  input  logic [fpu_fmt_pkg::FRACT28_W-1:0] add_fract28_i,
  input  logic                             add_inv_i,
  input  logic                             add_inf_i,
  input  logic                             add_snan_i,
  input  logic                             add_qnan_i,
  input  logic                             add_anan_sign_i,
  // mul/div source
  input  logic                             mul_rdy_i,
  input  logic                             mul_sign_i,
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]  mul_shr_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  mul_exp10shr_i,
  input  logic                             mul_shl_i,  // at most one step left
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  mul_exp10shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  mul_exp10sh0_i,
  input  logic [fpu_fmt_pkg::FRACT28_W-1:0] mul_fract28_i,
  input  logic                             mul_inv_i,
  input  logic                             mul_inf_i,
  input  logic                             mul_snan_i,
  input  logic                             mul_qnan_i,
  input  logic                             mul_anan_sign_i,
  // divider side-band
  input  logic                             div_op_i,
  input  logic                             div_sign_rmnd_i,
  input  logic                             div_dbz_i,
  // stage one register
  output logic                             s1_sign_o,
  output logic [fpu_fmt_pkg::EXP10_W-1:0]  s1_exp10_o,
  output logic [fpu_fmt_pkg::FRAC_W:0]     s1_fract24_o,
  output logic [1:0]                       s1_rs_o,  // {round, sticky}
  output logic                             s1_ready_o,
  output logic                             s1_inv_o,
  output logic                             s1_inf_o,
  output logic                             s1_snan_o,
  output logic                             s1_qnan_o,
  output logic                             s1_anan_sign_o,
  output logic                             s1_div_op_o,
  output logic                             s1_div_sign_rmnd_o,
  output logic                             s1_div_dbz_o
);
  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  logic                 add_sign;
  logic                 t_sign, t_inv, t_inf, t_snan, t_qnan, t_anan_sign;
  logic [FRACT28_W-1:0] t_fract28, t_fract_sh, t_out_mask;
  logic                 t_carry, t_sticky;
  logic [SHIFT_W-1:0]   t_shr_req, t_shr, t_shl;
  logic [EXP10_W-1:0]   t_exp_shl, t_exp_sh0, t_exp10;

  // +0 from x-x unless rounding toward -inf
  assign add_sign = add_sub_0_i ? (rmode_i == RM_TO_INFM) : add_sign_i;

  //////////////////////////////
  // source select
  //////////////////////////////
  assign {t_sign, t_inv, t_inf, t_snan, t_qnan, t_anan_sign} = mul_rdy_i ?
    {mul_sign_i, mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_anan_sign_i} :
    {add_sign, add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i};

  assign t_fract28 = mul_rdy_i ? mul_fract28_i : add_fract28_i;
  assign t_carry   = t_fract28[FRACT28_W-1];  // add/mul overflowed by one bit
  assign t_shr_req = mul_rdy_i ? mul_shr_i : '0;  // add/sub never shifts right
  assign t_shl     = mul_rdy_i ? SHIFT_W'(mul_shl_i) : add_shl_i;
  assign t_exp_shl = mul_rdy_i ? mul_exp10shl_i : add_exp10shl_i;
  assign t_exp_sh0 = mul_rdy_i ? mul_exp10sh0_i : add_exp10sh0_i;

  //////////////////////////////
  // align shift and sticky
  //////////////////////////////
  // requested right shift beats carry, any right shift beats left
  assign t_shr = (|t_shr_req) ? t_shr_req : SHIFT_W'(t_carry);

  assign t_fract_sh = (|t_shr) ? (t_fract28 >> t_shr) : (t_fract28 << t_shl);

  // bits dropped off the bottom on a right shift
  assign t_out_mask = (|t_shr) ? ((FRACT28_W'(1) << t_shr) - 1'b1) : '0;
  assign t_sticky   = (|t_fract_sh[1:0]) | (|(t_fract28 & t_out_mask));

  assign t_exp10 = (|t_shr_req)   ? mul_exp10shr_i :
                   (t_shl == '0)  ? (t_exp_sh0 + EXP10_W'(t_carry)) :
                                    t_exp_shl;

  // payload, no reset
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign_o    <= t_sign;
      s1_exp10_o   <= t_exp10;
      s1_fract24_o <= t_fract_sh[FRACT28_W-2:3];  // hidden bit down to lsb
      s1_rs_o      <= {t_fract_sh[2], t_sticky};
      s1_inv_o       <= t_inv;
      s1_inf_o       <= t_inf;
      s1_snan_o      <= t_snan;
      s1_qnan_o      <= t_qnan;
      s1_anan_sign_o <= t_anan_sign;
      // quotient specials only valid with a mul/div source
      s1_div_op_o        <= mul_rdy_i & div_op_i;
      s1_div_sign_rmnd_o <= div_sign_rmnd_i;
      s1_div_dbz_o       <= div_dbz_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_ready_o <= 1'b0;
    end else if (flush_i) begin
      s1_ready_o <= 1'b0;
    end else if (adv_i) begin
      s1_ready_o <= add_rdy_i | mul_rdy_i;
    end
  end

  // upstream units share this stage, never both at once
  a_one_source : assert property (@(posedge clk) disable iff (rst)
    !(add_rdy_i && mul_rdy_i))
    else $error("add and mul sources ready together");

endmodule

//--- fpu_round.sv
module fpu_round (
  input  fpu_ctrl_pkg::rmode_e            rmode_i,
  input  logic                            s1_sign_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0] s1_exp10_i,
  input  logic [fpu_fmt_pkg::FRAC_W:0]    s1_fract24_i,
  input  logic [1:0]                      s1_rs_i,
  input  logic                            s1_div_op_i,
  input  logic                            s1_div_sign_rmnd_i,  // remainder sign
  output logic [fpu_fmt_pkg::EXP10_W-1:0] rnd_exp10_o,
  output logic [fpu_fmt_pkg::FRAC_W:0]    rnd_fract24_o,
  output logic                            rnd_lost_o
);
  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  logic              g, r, s;
  logic              nearest, away, toward;
  logic              rnd_up, div_up, div_dn, n_qtnt, set_up, set_dn;
  logic [FRAC_W+1:0] rnd_v, fract25;
  logic              carry;

  assign g = s1_fract24_i[0];  // guard, lsb kept
  assign r = s1_rs_i[1];
  assign s = s1_rs_i[0];
  assign rnd_lost_o = r | s;

  assign nearest = (rmode_i == RM_NEAREST);
  // directed modes, relative to the magnitude
  assign away   = ((rmode_i == RM_TO_INFP) & ~s1_sign_i) | ((rmode_i == RM_TO_INFM) & s1_sign_i);
  assign toward = ((rmode_i == RM_TO_INFP) & s1_sign_i) | ((rmode_i == RM_TO_INFM) & ~s1_sign_i);

  //////////////////////////////
  // round direction
  //////////////////////////////
  assign rnd_up = (nearest & r & s) |
                  (nearest & g & r & ~s) |  // tie, go even
                  (away & rnd_lost_o);

  // quotient with remainder sign: true value sits below/above the r,s bits
  assign div_up = (nearest & r & s & ~s1_div_sign_rmnd_i) |
                  (away & ((r & s) | (~r & s & ~s1_div_sign_rmnd_i)));
  assign div_dn = ~r & s & s1_div_sign_rmnd_i & ((rmode_i == RM_TO_ZERO) | toward);

  assign n_qtnt = s1_div_op_i & s1_fract24_i[FRAC_W];  // normalized quotient only
  assign set_up = n_qtnt ? div_up : rnd_up;
  assign set_dn = n_qtnt & div_dn;

  assign rnd_v = set_up ? (FRAC_W+2)'(1) :
                 set_dn ? '1 :  // minus one
                          '0;

  assign fract25 = {1'b0, s1_fract24_i} + rnd_v;

  // rounding carry, renormalize one step
  assign carry         = fract25[FRAC_W+1];
  assign rnd_exp10_o   = s1_exp10_i + EXP10_W'(carry);
  assign rnd_fract24_o = carry ? fract25[FRAC_W+1:1] : fract25[FRAC_W:0];

endmodule

//--- fpu_result_pack.sv
module fpu_result_pack (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            adv_i,
  // stage one
  input  logic                            s1_sign_i,
  input  logic                            s1_ready_i,
  input  logic                            s1_inv_i,
  input  logic                            s1_inf_i,
  input  logic                            s1_snan_i,
  input  logic                            s1_qnan_i,
  input  logic                            s1_anan_sign_i,
  input  logic                            s1_div_dbz_i,
  // rounder
  input  logic [fpu_fmt_pkg::EXP10_W-1:0] rnd_exp10_i,
  input  logic [fpu_fmt_pkg::FRAC_W:0]    rnd_fract24_i,
  input  logic                            rnd_lost_i,
  // comparator
  input  logic                            cmp_rdy_i,
  input  logic                            cmp_res_i,
  input  logic                            cmp_inv_i,
  input  logic                            cmp_inf_i,
  // outputs
  output logic [31:0]                     fpu_result_o,
  output logic                            fpu_arith_valid_o,
  output logic                            fpu_cmp_flag_o,
  output logic                            fpu_cmp_valid_o,
  output logic [fpu_ctrl_pkg::FPCSR_W-1:0] fpcsr_o
);
  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  sp_word_u           res;
  logic               f_ovf, f_unf, f_zf, f_ixf, f_inf;
  logic [FPCSR_W-1:0] arith_flags, flags;

  //////////////////////////////
  // special case select
  //////////////////////////////
  always_comb begin
    res.f.sign = s1_sign_i;
    res.f.exp  = rnd_exp10_i[EXP_W-1:0];
    res.f.frac = rnd_fract24_i[FRAC_W-1:0];
    f_ovf = 1'b0;
    f_unf = 1'b0;
    f_zf  = 1'b0;
    f_ixf = rnd_lost_i;
    f_inf = 1'b0;
    if (s1_snan_i | s1_qnan_i) begin           // nan in, quiet nan out
      res.f.sign = s1_anan_sign_i;
      {res.f.exp, res.f.frac} = QNAN_BODY;
      f_ixf = 1'b0;
    end else if (s1_inv_i) begin
      {res.f.exp, res.f.frac} = SNAN_BODY;
      f_ixf = 1'b0;
    end else if ((rnd_exp10_i > EXP10_W'(EXP_MAX_NORMAL)) | s1_inf_i | s1_div_dbz_i) begin
      {res.f.exp, res.f.frac} = INF_BODY;
      f_ovf = ~s1_inf_i & ~s1_div_dbz_i;           // real overflow only
      f_ixf = (rnd_lost_i | ~s1_inf_i) & ~s1_div_dbz_i;
      f_inf = 1'b1;
    end else if (!rnd_fract24_i[FRAC_W]) begin    // denormal or zero
      res.f.exp = '0;
      f_unf = rnd_lost_i;
      f_zf  = ~(|rnd_fract24_i);
    end
  end

  // flag word, arithmetic part
  always_comb begin
    arith_flags = '0;
    arith_flags[FPCSR_OVF] = f_ovf;
    arith_flags[FPCSR_UNF] = f_unf;
    arith_flags[FPCSR_SNF] = s1_inv_i;
    arith_flags[FPCSR_QNF] = s1_qnan_i;
    arith_flags[FPCSR_ZF]  = f_zf;
    arith_flags[FPCSR_IXF] = f_ixf;
    arith_flags[FPCSR_IVF] = s1_inv_i | s1_snan_i;
    arith_flags[FPCSR_INF] = f_inf;
    arith_flags[FPCSR_DZF] = s1_div_dbz_i;
    flags = arith_flags & {FPCSR_W{s1_ready_i}};  // idle stage adds nothing
    flags[FPCSR_IVF] = flags[FPCSR_IVF] | (cmp_inv_i & cmp_rdy_i);
    flags[FPCSR_INF] = flags[FPCSR_INF] | (cmp_inf_i & cmp_rdy_i);
  end

  //////////////////////////////
  // output register
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fpu_result_o      <= '0;
      fpu_arith_valid_o <= 1'b0;
      fpu_cmp_flag_o    <= 1'b0;
      fpu_cmp_valid_o   <= 1'b0;
      fpcsr_o           <= '0;
    end else if (flush_i) begin
      fpu_result_o      <= '0;
      fpu_arith_valid_o <= 1'b0;
      fpu_cmp_flag_o    <= 1'b0;
      fpu_cmp_valid_o   <= 1'b0;
      fpcsr_o           <= '0;
    end else if (adv_i) begin
      fpu_result_o      <= res.raw;
      fpu_arith_valid_o <= s1_ready_i;
      fpu_cmp_flag_o    <= cmp_res_i;   // comparator skips stage one
      fpu_cmp_valid_o   <= cmp_rdy_i;
      fpcsr_o           <= flags;
    end
  end

  // stage one is cleared as well, so the next load after a clear is idle too
  a_no_valid_after_clear : assert property (@(posedge clk)
    ($past(rst) || $past(flush_i)) |=> !fpu_arith_valid_o)
    else $error("arith valid set right after reset/flush");

endmodule

//--- fpu_rnd_top.sv
module fpu_rnd_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush_i,
  input  logic                             adv_i,
  input  fpu_ctrl_pkg::rmode_e             rmode_i,
  // add/sub
  input  logic                             add_rdy_i,
  input  logic                             add_sign_i,
  input  logic                             add_sub_0_i,
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]  add_shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  add_exp10shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  add_exp10sh0_i,
  input  logic [fpu_fmt_pkg::FRACT28_W-1:0] add_fract28_i,
  input  logic                             add_inv_i,
  input  logic                             add_inf_i,
  input  logic                             add_snan_i,
  input  logic                             add_qnan_i,
  input  logic                             add_anan_sign_i,
  // mul/div
  input  logic                             mul_rdy_i,
  input  logic                             mul_sign_i,
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]  mul_shr_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  mul_exp10shr_i,
  input  logic                             mul_shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  mul_exp10shl_i,
  input  logic [fpu_fmt_pkg::EXP10_W-1:0]  mul_exp10sh0_i,
  input  logic [fpu_fmt_pkg::FRACT28_W-1:0] mul_fract28_i,
  input  logic                             mul_inv_i,
  input  logic                             mul_inf_i,
  input  logic                             mul_snan_i,
  input  logic                             mul_qnan_i,
  input  logic                             mul_anan_sign_i,
  input  logic                             div_op_i,
  input  logic                             div_sign_rmnd_i,
  input  logic                             div_dbz_i,
  // comparator
  input  logic                             cmp_rdy_i,
  input  logic                             cmp_res_i,
  input  logic                             cmp_inv_i,
  input  logic                             cmp_inf_i,
  // results
  output logic [31:0]                      fpu_result_o,
  output logic                             fpu_arith_valid_o,
  output logic                             fpu_cmp_flag_o,
  output logic                             fpu_cmp_valid_o,
  output logic [fpu_ctrl_pkg::FPCSR_W-1:0] fpcsr_o
);
  import fpu_fmt_pkg::*;

  // stage one register
  logic               s1_sign, s1_ready, s1_inv, s1_inf, s1_snan, s1_qnan, s1_anan_sign;
  logic               s1_div_op, s1_div_sign_rmnd, s1_div_dbz;
  logic [EXP10_W-1:0] s1_exp10;
  logic [FRAC_W:0]    s1_fract24;
  logic [1:0]         s1_rs;
  // rounder out, same cycle
  logic [EXP10_W-1:0] rnd_exp10;
  logic [FRAC_W:0]    rnd_fract24;
  logic               rnd_lost;

  fpu_align fpu_align_i (
    .clk, .rst, .flush_i, .adv_i, .rmode_i,
    .add_rdy_i, .add_sign_i, .add_sub_0_i, .add_shl_i, .add_exp10shl_i, .add_exp10sh0_i,
    .add_fract28_i, .add_inv_i, .add_inf_i, .add_snan_i, .add_qnan_i, .add_anan_sign_i,
    .mul_rdy_i, .mul_sign_i, .mul_shr_i, .mul_exp10shr_i, .mul_shl_i, .mul_exp10shl_i,
    .mul_exp10sh0_i, .mul_fract28_i, .mul_inv_i, .mul_inf_i, .mul_snan_i, .mul_qnan_i,
    .mul_anan_sign_i, .div_op_i, .div_sign_rmnd_i, .div_dbz_i,
    .s1_sign_o (s1_sign),     .s1_exp10_o (s1_exp10),  .s1_fract24_o (s1_fract24),
    .s1_rs_o   (s1_rs),       .s1_ready_o (s1_ready),  .s1_inv_o     (s1_inv),
    .s1_inf_o  (s1_inf),      .s1_snan_o  (s1_snan),   .s1_qnan_o    (s1_qnan),
    .s1_anan_sign_o (s1_anan_sign), .s1_div_op_o (s1_div_op),
    .s1_div_sign_rmnd_o (s1_div_sign_rmnd), .s1_div_dbz_o (s1_div_dbz)
  );

  fpu_round fpu_round_i (
    .rmode_i, .s1_sign_i (s1_sign), .s1_exp10_i (s1_exp10), .s1_fract24_i (s1_fract24),
    .s1_rs_i (s1_rs), .s1_div_op_i (s1_div_op), .s1_div_sign_rmnd_i (s1_div_sign_rmnd),
    .rnd_exp10_o (rnd_exp10), .rnd_fract24_o (rnd_fract24), .rnd_lost_o (rnd_lost)
  );

  fpu_result_pack fpu_result_pack_i (
    .clk, .rst, .flush_i, .adv_i,
    .s1_sign_i (s1_sign), .s1_ready_i (s1_ready), .s1_inv_i (s1_inv), .s1_inf_i (s1_inf),
    .s1_snan_i (s1_snan), .s1_qnan_i (s1_qnan), .s1_anan_sign_i (s1_anan_sign),
    .s1_div_dbz_i (s1_div_dbz),
    .rnd_exp10_i (rnd_exp10), .rnd_fract24_i (rnd_fract24), .rnd_lost_i (rnd_lost),
    .cmp_rdy_i, .cmp_res_i, .cmp_inv_i, .cmp_inf_i,
    .fpu_result_o, .fpu_arith_valid_o, .fpu_cmp_flag_o, .fpu_cmp_valid_o, .fpcsr_o
  );

endmodule

//--- tb_fpu_rnd.sv
module tb_fpu_rnd;
  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  localparam string TEST_FILE = "fpu_rnd_tests.txt";

  // dut ports, same names so .* hooks them up
  logic                 clk, rst, flush_i, adv_i;
  rmode_e               rmode_i;
  logic                 add_rdy_i, add_sign_i, add_sub_0_i;
  logic [SHIFT_W-1:0]   add_shl_i;
  logic [EXP10_W-1:0]   add_exp10shl_i, add_exp10sh0_i;
  logic [FRACT28_W-1:0] add_fract28_i;
  logic                 add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i;
  logic                 mul_rdy_i, mul_sign_i, mul_shl_i;
  logic [SHIFT_W-1:0]   mul_shr_i;
  logic [EXP10_W-1:0]   mul_exp10shr_i, mul_exp10shl_i, mul_exp10sh0_i;
  logic [FRACT28_W-1:0] mul_fract28_i;
  logic                 mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_anan_sign_i;
  logic                 div_op_i, div_sign_rmnd_i, div_dbz_i;
  logic                 cmp_rdy_i, cmp_res_i, cmp_inv_i, cmp_inf_i;
  logic [31:0]          fpu_result_o;
  logic                 fpu_arith_valid_o, fpu_cmp_flag_o, fpu_cmp_valid_o;
  logic [FPCSR_W-1:0]   fpcsr_o;

  // fields of the current test line
  logic [8*24-1:0]      cur_name;
  int                   cur_src;  // 0 add, 1 mul, 2 cmp only
  logic [1:0]           cur_rm;
  logic                 cur_sign, cur_sub0;
  logic [SHIFT_W-1:0]   cur_shl, cur_shr;
  logic [EXP10_W-1:0]   cur_eshr, cur_eshl, cur_esh0;
  logic [FRACT28_W-1:0] cur_fract;
  logic [4:0]           cur_spec;   // {inv, inf, snan, qnan, anan_sign}
  logic [2:0]           cur_div;    // {op, rmnd sign, dbz}
  logic [3:0]           cur_cmp;    // {rdy, res, inv, inf}
  logic [31:0]          cur_res;
  logic [FPCSR_W-1:0]   cur_fpcsr;

  string lines[$];
  int    n_checks = 0;
  int    timeout_cycles = 0;

  fpu_rnd_top fpu_rnd_top_i (.*);

  always #4 clk = ~clk;  // period 8

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      $display("mismatch %0s %0s: expected %h, actual %h", cur_name, what, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "first error, run stopped");
    end
  endtask

  // word shown raw and as sign/exp/frac
  task automatic check_result();
    sp_word_u exp_w, act_w;
    exp_w.raw = cur_res;
    act_w.raw = fpu_result_o;
    check_value($sformatf("result (s/e/f %0d/%h/%h vs %0d/%h/%h)", exp_w.f.sign,
                exp_w.f.exp, exp_w.f.frac, act_w.f.sign, act_w.f.exp, act_w.f.frac),
                cur_res, fpu_result_o);
  endtask

  task automatic clear_inputs();
    {add_rdy_i, add_sign_i, add_sub_0_i} = '0;
    {add_shl_i, add_exp10shl_i, add_exp10sh0_i, add_fract28_i} = '0;
    {add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i} = '0;
    {mul_rdy_i, mul_sign_i, mul_shl_i, mul_shr_i} = '0;
    {mul_exp10shr_i, mul_exp10shl_i, mul_exp10sh0_i, mul_fract28_i} = '0;
    {mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_anan_sign_i} = '0;
    {div_op_i, div_sign_rmnd_i, div_dbz_i} = '0;
    {cmp_rdy_i, cmp_res_i, cmp_inv_i, cmp_inf_i} = '0;
  endtask

  task automatic drive_source();
    rmode_i = rmode_e'(cur_rm);
    {div_op_i, div_sign_rmnd_i, div_dbz_i} = cur_div;
    if (cur_src == 0) begin
      add_rdy_i      = 1'b1;
      add_sign_i     = cur_sign;
      add_sub_0_i    = cur_sub0;
      add_shl_i      = cur_shl;
      add_exp10shl_i = cur_eshl;
      add_exp10sh0_i = cur_esh0;
      add_fract28_i  = cur_fract;
      {add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i} = cur_spec;
    end else begin
      mul_rdy_i      = 1'b1;
      mul_sign_i     = cur_sign;
      mul_shl_i      = cur_shl[0];  // one bit on this source
      mul_shr_i      = cur_shr;
      mul_exp10shr_i = cur_eshr;
      mul_exp10shl_i = cur_eshl;
      mul_exp10sh0_i = cur_esh0;
      mul_fract28_i  = cur_fract;
      {mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_anan_sign_i} = cur_spec;
    end
  endtask

  // parse one line, apply it, check after the fixed pipe delay
  task automatic run_line(input int idx);
    int n;
    n = $sscanf(lines[idx], "%s %d %d %b %b %h %h %h %h %h %h %b %b %b %h %h",
                cur_name, cur_src, cur_rm, cur_sign, cur_sub0, cur_shl, cur_shr, cur_eshr,
                cur_eshl, cur_esh0, cur_fract, cur_spec, cur_div, cur_cmp, cur_res,
                cur_fpcsr);
    if (n != 16) begin
      $display("test line %0d could not be parsed: %s", idx, lines[idx]);
      $display("Simulation finished: FAIL");
      $fatal(1, "bad test file");
    end
    if (cur_src == 2) begin
      {cmp_rdy_i, cmp_res_i, cmp_inv_i, cmp_inf_i} = cur_cmp;
      @(posedge clk);  // comparator, one edge
      #1;
      check_value("cmp flag", 32'(cur_cmp[2]), 32'(fpu_cmp_flag_o));
      check_value("cmp valid", 1, 32'(fpu_cmp_valid_o));
      check_value("arith valid", 0, 32'(fpu_arith_valid_o));
      check_value("fpcsr", 32'(cur_fpcsr), 32'(fpcsr_o));
    end else begin
      drive_source();
      @(posedge clk);  // into stage one
      #1;
      clear_inputs();
      {cmp_rdy_i, cmp_res_i, cmp_inv_i, cmp_inf_i} = cur_cmp;  // lands with result
      @(posedge clk);  // into output reg
      #1;
      check_result();
      check_value("arith valid", 1, 32'(fpu_arith_valid_o));
      check_value("fpcsr", 32'(cur_fpcsr), 32'(fpcsr_o));
      check_value("cmp valid", 32'(cur_cmp[3]), 32'(fpu_cmp_valid_o));
      if (cur_cmp[3]) begin
        check_value("cmp flag", 32'(cur_cmp[2]), 32'(fpu_cmp_flag_o));
      end
    end
    clear_inputs();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin : main
    int    fd;
    string line;
    clk     = 1'b0;
    rst     = 1'b1;
    flush_i = 1'b0;
    adv_i   = 1'b0;
    rmode_i = RM_NEAREST;
    clear_inputs();
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", TEST_FILE);
      $display("Simulation finished: FAIL");
      $fatal(1, "no test file");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin  // skip blanks, comments
          lines.push_back(line);
        end
      end
    end
    $fclose(fd);
    if (lines.size() < 2) begin
      $display("too few test lines in %s", TEST_FILE);
      $display("Simulation finished: FAIL");
      $fatal(1, "short test file");
    end
    timeout_cycles = lines.size() * 10 + 100;

    repeat (16) @(posedge clk);
    #1;
    rst   = 1'b0;
    adv_i = 1'b1;
    cur_name = "reset";
    check_value("arith valid", 0, 32'(fpu_arith_valid_o));
    check_value("cmp valid", 0, 32'(fpu_cmp_valid_o));
    check_value("fpcsr", 0, 32'(fpcsr_o));

    for (int i = 0; i < lines.size(); i++) begin
      run_line(i);
    end

    // adv low, new stimulus must not reach the outputs
    run_line(1);
    adv_i          = 1'b0;
    add_rdy_i      = 1'b1;
    add_exp10sh0_i = 10'h0ff;
    add_fract28_i  = 28'h7ffffff;
    {cmp_rdy_i, cmp_res_i, cmp_inv_i} = 3'b111;
    repeat (3) @(posedge clk);
    #1;
    cur_name = "adv_low_hold";
    check_result();
    check_value("arith valid", 1, 32'(fpu_arith_valid_o));
    check_value("fpcsr", 32'(cur_fpcsr), 32'(fpcsr_o));
    check_value("cmp valid", 0, 32'(fpu_cmp_valid_o));
    check_value("cmp flag", 0, 32'(fpu_cmp_flag_o));
    clear_inputs();
    adv_i = 1'b1;

    // flush with an op in stage one and another one arriving
    cur_name       = "flush";
    add_rdy_i      = 1'b1;
    add_exp10sh0_i = 10'h07f;
    add_fract28_i  = 28'h4000000;
    cmp_rdy_i      = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b1;  // source and cmp still up on the flush edge
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    clear_inputs();
    check_value("result", 0, fpu_result_o);
    check_value("arith valid", 0, 32'(fpu_arith_valid_o));
    check_value("cmp valid", 0, 32'(fpu_cmp_valid_o));
    check_value("fpcsr", 0, 32'(fpcsr_o));
    @(posedge clk);
    #1;
    check_value("arith valid after flush", 0, 32'(fpu_arith_valid_o));  // s1 dropped too

    if (n_checks == 0) begin
      $display("no checks were run");
      $display("Simulation finished: FAIL");
      $fatal(1, "empty run");
    end else begin
      $display("%0d checks over %0d test lines", n_checks, lines.size());
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // limit scales with the number of test lines
  initial begin : watchdog
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("run timed out after %0d cycles", timeout_cycles);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule

//--- fpu_rnd_tests.txt
# name src rm sign sub0 shl shr exp_shr exp_shl exp_sh0 fract28 spec div cmp exp_res exp_fpcsr
# src 0 add 1 mul 2 cmp, spec {inv inf snan qnan anan}, div {op rmnd dbz}, cmp {rdy res inv inf}
add_exact_rn     0 0 0 0 00 00 000 000 07f 4000000 00000 000 0000 3f800000 000
add_tie_even_dn  0 0 0 0 00 00 000 000 07f 4000004 00000 000 0000 3f800000 020
add_tie_even_up  0 0 0 0 00 00 000 000 07f 400000c 00000 000 0000 3f800002 020
add_rz_trunc     0 1 0 0 00 00 000 000 07f 400000e 00000 000 0000 3f800001 020
add_rp_pos_up    0 2 0 0 00 00 000 000 07f 4000001 00000 000 0000 3f800001 020
add_rp_neg_dn    0 2 1 0 00 00 000 000 07f 4000001 00000 000 0000 bf800000 020
add_rm_pos_dn    0 3 0 0 00 00 000 000 07f 4000001 00000 000 0000 3f800000 020
add_rm_neg_up    0 3 1 0 00 00 000 000 07f 4000001 00000 000 0000 bf800001 020
add_zero_rm      0 3 0 1 00 00 000 000 000 0000000 00000 000 0000 80000000 010
add_zero_rn      0 0 1 1 00 00 000 000 000 0000000 00000 000 0000 00000000 010
add_shl_exact    0 0 0 0 03 00 000 07c 000 0800000 00000 000 0000 3e000000 000
add_carry        0 0 0 0 00 00 000 000 07f 8000000 00000 000 0000 40000000 000
mul_shr_sticky   1 0 0 0 00 01 07f 000 000 8000009 00000 000 0000 3f800001 020
mul_shr_tie      1 0 0 0 00 01 07f 000 000 8000008 00000 000 0000 3f800000 020
mul_rnd_carry    1 0 0 0 00 00 000 000 07f 7fffffc 00000 000 0000 40000000 020
mul_shl_one      1 0 0 0 01 00 000 07e 000 2000000 00000 000 0000 3f000000 000
ovf_inf          0 0 0 0 00 00 000 000 0ff 4000000 00000 000 0000 7f800000 0a1
denorm_lost      0 0 0 0 00 00 000 000 000 0000014 00000 000 0000 00000002 022
denorm_zero_lost 0 0 0 0 00 00 000 000 000 0000004 00000 000 0000 00000000 032
nan_quiet        0 0 0 0 00 00 000 000 07f 4000000 00011 000 0000 ffc00000 008
nan_signaling    0 0 0 0 00 00 000 000 07f 4000000 00100 000 0000 7fc00000 040
invalid_op       1 0 1 0 00 00 000 000 07f 4000000 10000 000 0000 ffbfffff 044
inf_input        0 0 1 0 00 00 000 000 07f 4000000 01000 000 0000 ff800000 080
div_by_zero      1 0 0 0 00 00 000 000 07f 4000000 00000 101 0000 7f800000 180
quot_rn_rmnd_pos 1 0 0 0 00 00 000 000 07f 4000006 00000 100 0000 3f800001 020
quot_rn_rmnd_neg 1 0 0 0 00 00 000 000 07f 4000006 00000 110 0000 3f800000 020
quot_rz_rmnd_pos 1 1 0 0 00 00 000 000 07f 4000012 00000 100 0000 3f800002 020
quot_rz_rmnd_neg 1 1 0 0 00 00 000 000 07f 4000012 00000 110 0000 3f800001 020
cmp_true         2 0 0 0 00 00 000 000 000 0000000 00000 000 1100 00000000 000
cmp_invalid      2 0 0 0 00 00 000 000 000 0000000 00000 000 1010 00000000 040
cmp_inf_true     2 0 0 0 00 00 000 000 000 0000000 00000 000 1101 00000000 080
inf_with_cmp_inv 0 0 0 0 00 00 000 000 07f 4000000 01000 000 1010 7f800000 0c0

//--- fpu_rnd.f
fpu_fmt_pkg.sv
fpu_ctrl_pkg.sv
fpu_align.sv
fpu_round.sv
fpu_result_pack.sv
fpu_rnd_top.sv
tb_fpu_rnd.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_fpu_rnd
RTL_TOP    := fpu_rnd_top
FILELIST   := fpu_rnd.f
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
